// ==== src/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// widths and sizes
`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_NREGS     32
`define RV_RESET_PC  32'h0000_0000

// addi x0, x0, 0
`define RV_NOP_INSTR 32'h0000_0013

// major opcodes
`define RV_OP_OP     7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011

// funct3, alu group
`define RV_F3_ADD    3'b000
`define RV_F3_SLL    3'b001
`define RV_F3_SLT    3'b010
`define RV_F3_SLTU   3'b011
`define RV_F3_XOR    3'b100
`define RV_F3_SR     3'b101
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111

// funct3, branch group
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_BLT    3'b100
`define RV_F3_BGE    3'b101

`endif

// ==== src/rv_pkg.sv ====
`default_nettype none
`include "rv_macros.svh"

package rv_pkg;

   ////////////////////
   // basic vectors
   typedef logic [`RV_XLEN-1:0]   word_t;
   typedef logic [`RV_XLEN-1:0]   addr_t;
   typedef logic [31:0]           instr_t;
   typedef logic [`RV_REG_AW-1:0] reg_idx_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_PASS_B
   } alu_op_e;

   // control flow kinds, resolved in decode (jal) or execute
   typedef enum logic [2:0] {
      BR_NONE,
      BR_BEQ,
      BR_BNE,
      BR_BLT,
      BR_BGE,
      BR_JAL,
      BR_JALR
   } br_kind_e;

   ////////////////////
   // stage packets
   typedef struct packed {
      logic   valid;
      addr_t  pc;
      instr_t instr;
   } fetch_pkt_t;

   typedef struct packed {
      logic     valid;
      addr_t    pc;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      logic     writes_rd;
      logic     uses_rs1;
      logic     uses_rs2;
      logic     op_a_is_pc;
      logic     op_b_is_imm;
      alu_op_e  alu_op;
      br_kind_e br_kind;
      word_t    imm;
      word_t    rs1_val;
      word_t    rs2_val;
   } decode_pkt_t;

   typedef struct packed {
      logic     valid;
      addr_t    pc;
      reg_idx_t rd;
      logic     writes_rd;
      word_t    data;
   } result_pkt_t;

   typedef struct packed {
      logic  taken;
      addr_t target;
   } redirect_t;

   // trace of one completed instruction
   typedef struct packed {
      logic     valid;
      addr_t    pc;
      reg_idx_t rd;
      word_t    data;
   } retire_t;

endpackage

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module fetch_unit (
   input  wire                clk,
   input  wire                rstn,
   input  wire rv_pkg::redirect_t ex_redirect,
   input  wire rv_pkg::redirect_t id_redirect,
   output rv_pkg::addr_t      rom_addr,
   input  wire rv_pkg::instr_t rom_data,
   output rv_pkg::fetch_pkt_t fetch_out
);

   rv_pkg::addr_t pc;
   rv_pkg::addr_t pc_next;
   logic          flush;

   // execute wins over decode, it belongs to an older instruction
   always_comb begin
      if (ex_redirect.taken) begin
         pc_next = ex_redirect.target;
      end else if (id_redirect.taken) begin
         pc_next = id_redirect.target;
      end else begin
         pc_next = pc + 32'd4;
      end
   end

   assign flush    = ex_redirect.taken || id_redirect.taken;
   assign rom_addr = pc;

   ////////////////////
   // pc and fetch register
   always_ff @(posedge clk) begin
      if (rstn) begin
         pc              <= `RV_RESET_PC;
         fetch_out.valid <= 1'b0;
      end else begin
         pc              <= pc_next;
         // word on the bus now is on the wrong path
         fetch_out.valid <= !flush;
         fetch_out.pc    <= pc;
         fetch_out.instr <= rom_data;
      end
   end

endmodule

`default_nettype wire

// ==== src/decode_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module decode_unit (
   input  wire                    clk,
   input  wire                    rstn,
   input  wire rv_pkg::fetch_pkt_t fetch_in,
   input  wire rv_pkg::redirect_t ex_redirect,
   output rv_pkg::reg_idx_t       rs1_idx,
   output rv_pkg::reg_idx_t       rs2_idx,
   input  wire rv_pkg::word_t     rs1_val,
   input  wire rv_pkg::word_t     rs2_val,
   output rv_pkg::redirect_t      id_redirect,
   output rv_pkg::decode_pkt_t    decode_out
);

   rv_pkg::instr_t      instr;
   logic [6:0]          opcode;
   logic [2:0]          funct3;
   logic [6:0]          funct7;
   rv_pkg::word_t       imm_i;
   rv_pkg::word_t       imm_u;
   rv_pkg::word_t       imm_j;
   rv_pkg::word_t       imm_b;
   logic                known;
   rv_pkg::decode_pkt_t dec_next;

   function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
      case (f3)
         `RV_F3_ADD:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
         `RV_F3_SLL:  return rv_pkg::ALU_SLL;
         `RV_F3_SLT:  return rv_pkg::ALU_SLT;
         `RV_F3_SLTU: return rv_pkg::ALU_SLTU;
         `RV_F3_XOR:  return rv_pkg::ALU_XOR;
         `RV_F3_SR:   return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
         `RV_F3_OR:   return rv_pkg::ALU_OR;
         default:     return rv_pkg::ALU_AND;
      endcase
   endfunction

   ////////////////////
   // fields and immediates
   assign instr  = fetch_in.instr;
   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

   // file read in the same cycle, value rides with the packet
   assign rs1_idx = instr[19:15];
   assign rs2_idx = instr[24:20];

   ////////////////////
   // control decode
   always_comb begin
      known            = 1'b0;
      dec_next         = '0;
      dec_next.pc      = fetch_in.pc;
      dec_next.rd      = instr[11:7];
      dec_next.rs1     = rs1_idx;
      dec_next.rs2     = rs2_idx;
      dec_next.alu_op  = rv_pkg::ALU_ADD;
      dec_next.br_kind = rv_pkg::BR_NONE;
      dec_next.rs1_val = rs1_val;
      dec_next.rs2_val = rs2_val;
      case (opcode)
         `RV_OP_OP: begin
            known = (funct7 == 7'b0000000) ||
                    (funct7 == 7'b0100000 && (funct3 == `RV_F3_ADD || funct3 == `RV_F3_SR));
            dec_next.writes_rd = 1'b1;
            dec_next.uses_rs1  = 1'b1;
            dec_next.uses_rs2  = 1'b1;
            dec_next.alu_op    = alu_sel(funct3, funct7[5]);
         end
         `RV_OP_IMM: begin
            if (funct3 == `RV_F3_SLL) begin
               known = (funct7 == 7'b0000000);
            end else if (funct3 == `RV_F3_SR) begin
               known = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
            end else begin
               known = 1'b1;
            end
            dec_next.writes_rd   = 1'b1;
            dec_next.uses_rs1    = 1'b1;
            dec_next.op_b_is_imm = 1'b1;
            dec_next.imm         = imm_i;
            // only shifts read bit 30 as a modifier
            dec_next.alu_op      = alu_sel(funct3, funct3 == `RV_F3_SR && funct7[5]);
         end
         `RV_OP_LUI: begin
            known                = 1'b1;
            dec_next.writes_rd   = 1'b1;
            dec_next.op_b_is_imm = 1'b1;
            dec_next.imm         = imm_u;
            dec_next.alu_op      = rv_pkg::ALU_PASS_B;
         end
         `RV_OP_AUIPC: begin
            known                = 1'b1;
            dec_next.writes_rd   = 1'b1;
            dec_next.op_a_is_pc  = 1'b1;
            dec_next.op_b_is_imm = 1'b1;
            dec_next.imm         = imm_u;
         end
         `RV_OP_JAL: begin
            known              = 1'b1;
            dec_next.writes_rd = 1'b1;
            dec_next.imm       = imm_j;
            dec_next.br_kind   = rv_pkg::BR_JAL;
         end
         `RV_OP_JALR: begin
            known              = (funct3 == 3'b000);
            dec_next.writes_rd = 1'b1;
            dec_next.uses_rs1  = 1'b1;
            dec_next.imm       = imm_i;
            dec_next.br_kind   = rv_pkg::BR_JALR;
         end
         `RV_OP_BRANCH: begin
            known             = 1'b1;
            dec_next.uses_rs1 = 1'b1;
            dec_next.uses_rs2 = 1'b1;
            dec_next.imm      = imm_b;
            case (funct3)
               `RV_F3_BEQ: dec_next.br_kind = rv_pkg::BR_BEQ;
               `RV_F3_BNE: dec_next.br_kind = rv_pkg::BR_BNE;
               `RV_F3_BLT: dec_next.br_kind = rv_pkg::BR_BLT;
               `RV_F3_BGE: dec_next.br_kind = rv_pkg::BR_BGE;
               default:    known = 1'b0;
            endcase
         end
         default: begin
            known = 1'b0;
         end
      endcase
      // unknown encodings drop out here and retire nothing
      dec_next.valid = fetch_in.valid && known && !ex_redirect.taken;
   end

   // jal target needs no register, redirect right away
   assign id_redirect.taken  = fetch_in.valid && (opcode == `RV_OP_JAL);
   assign id_redirect.target = fetch_in.pc + imm_j;

   always_ff @(posedge clk) begin
      if (rstn) begin
         decode_out.valid <= 1'b0;
      end else begin
         decode_out <= dec_next;
      end
   end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module reg_file (
   input  wire                  clk,
   input  wire                  rstn,
   input  wire rv_pkg::reg_idx_t rs1_idx,
   input  wire rv_pkg::reg_idx_t rs2_idx,
   output rv_pkg::word_t        rs1_val,
   output rv_pkg::word_t        rs2_val,
   input  wire                  wr_en,
   input  wire rv_pkg::reg_idx_t wr_idx,
   input  wire rv_pkg::word_t    wr_data
);

   rv_pkg::word_t regs [`RV_NREGS];

   // x0 reads zero and a same-cycle write passes straight through
   function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end
      if (wr_en && wr_idx == idx) begin
         return wr_data;
      end
      return regs[idx];
   endfunction

   always_comb begin
      rs1_val = read_port(rs1_idx);
      rs2_val = read_port(rs2_idx);
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < `RV_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_idx != '0) begin
         regs[wr_idx] <= wr_data;
      end
   end

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module execute_unit (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire rv_pkg::decode_pkt_t decode_in,
   input  wire rv_pkg::result_pkt_t fwd_in,
   output rv_pkg::redirect_t       ex_redirect,
   output rv_pkg::result_pkt_t     result_out
);

   rv_pkg::word_t src1;
   rv_pkg::word_t src2;
   rv_pkg::word_t op_a;
   rv_pkg::word_t op_b;
   logic [4:0]    shamt;
   rv_pkg::word_t alu_res;
   rv_pkg::addr_t link_pc;
   logic          is_jump;
   logic          br_cond;
   rv_pkg::addr_t jalr_sum;

   // older neighbour sits in the result stage
   function automatic rv_pkg::word_t fwd_sel(input logic uses, input rv_pkg::reg_idx_t idx,
                                             input rv_pkg::word_t val);
      if (uses && fwd_in.valid && fwd_in.writes_rd && fwd_in.rd != '0 && fwd_in.rd == idx) begin
         return fwd_in.data;
      end
      return val;
   endfunction

   ////////////////////
   // operands
   always_comb begin
      src1 = fwd_sel(decode_in.uses_rs1, decode_in.rs1, decode_in.rs1_val);
      src2 = fwd_sel(decode_in.uses_rs2, decode_in.rs2, decode_in.rs2_val);
   end

   assign op_a  = decode_in.op_a_is_pc ? decode_in.pc : src1;
   assign op_b  = decode_in.op_b_is_imm ? decode_in.imm : src2;
   assign shamt = op_b[4:0];

   ////////////////////
   // alu
   always_comb begin
      case (decode_in.alu_op)
         rv_pkg::ALU_ADD:  alu_res = op_a + op_b;
         rv_pkg::ALU_SUB:  alu_res = op_a - op_b;
         rv_pkg::ALU_AND:  alu_res = op_a & op_b;
         rv_pkg::ALU_OR:   alu_res = op_a | op_b;
         rv_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
         rv_pkg::ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
         rv_pkg::ALU_SLTU: alu_res = {31'b0, op_a < op_b};
         rv_pkg::ALU_SLL:  alu_res = op_a << shamt;
         rv_pkg::ALU_SRL:  alu_res = op_a >> shamt;
         rv_pkg::ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
         default:          alu_res = op_b;
      endcase
   end

   ////////////////////
   // branch and jump resolution
   assign link_pc  = decode_in.pc + 32'd4;
   assign is_jump  = (decode_in.br_kind == rv_pkg::BR_JAL) ||
                     (decode_in.br_kind == rv_pkg::BR_JALR);
   assign jalr_sum = src1 + decode_in.imm;

   always_comb begin
      case (decode_in.br_kind)
         rv_pkg::BR_BEQ:  br_cond = (src1 == src2);
         rv_pkg::BR_BNE:  br_cond = (src1 != src2);
         rv_pkg::BR_BLT:  br_cond = ($signed(src1) < $signed(src2));
         rv_pkg::BR_BGE:  br_cond = ($signed(src1) >= $signed(src2));
         rv_pkg::BR_JALR: br_cond = 1'b1;
         default:         br_cond = 1'b0;
      endcase
   end

   // jal already steered fetch from decode
   assign ex_redirect.taken  = decode_in.valid && br_cond;
   assign ex_redirect.target = (decode_in.br_kind == rv_pkg::BR_JALR) ?
                               {jalr_sum[31:1], 1'b0} : decode_in.pc + decode_in.imm;

   always_ff @(posedge clk) begin
      if (rstn) begin
         result_out.valid <= 1'b0;
      end else begin
         result_out.valid     <= decode_in.valid;
         result_out.pc        <= decode_in.pc;
         result_out.rd        <= decode_in.rd;
         result_out.writes_rd <= decode_in.writes_rd;
         result_out.data      <= is_jump ? link_pc : alu_res;
      end
   end

endmodule

`default_nettype wire

// ==== src/result_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module result_stage (
   input  wire                     clk,
   input  wire                     rstn,
   input  wire rv_pkg::result_pkt_t result_in,
   output logic                    wr_en,
   output rv_pkg::reg_idx_t        wr_idx,
   output rv_pkg::word_t           wr_data,
   output rv_pkg::result_pkt_t     fwd_out,
   output rv_pkg::retire_t         retire
);

   logic has_dest;

   // packet is held in the execute register, written at the closing edge
   assign has_dest = result_in.writes_rd && (result_in.rd != '0);

   assign wr_en   = result_in.valid && has_dest;
   assign wr_idx  = result_in.rd;
   assign wr_data = result_in.data;

   assign fwd_out = result_in;

   ////////////////////
   // trace port
   // x0 targets and branches report rd 0, data 0
   assign retire.valid = result_in.valid;
   assign retire.pc    = result_in.pc;
   assign retire.rd    = has_dest ? result_in.rd : '0;
   assign retire.data  = has_dest ? result_in.data : '0;

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module rv_core (
   input  wire                clk,
   input  wire                rstn,
   output rv_pkg::addr_t      rom_addr,
   input  wire rv_pkg::instr_t rom_data,
   output rv_pkg::retire_t    retire
);

   rv_pkg::fetch_pkt_t  fetch_pkt;
   rv_pkg::decode_pkt_t decode_pkt;
   rv_pkg::result_pkt_t result_pkt;
   rv_pkg::result_pkt_t fwd_pkt;
   rv_pkg::redirect_t   ex_redirect;
   rv_pkg::redirect_t   id_redirect;

   // register file ports
   rv_pkg::reg_idx_t rs1_idx;
   rv_pkg::reg_idx_t rs2_idx;
   rv_pkg::word_t    rs1_val;
   rv_pkg::word_t    rs2_val;
   logic             wr_en;
   rv_pkg::reg_idx_t wr_idx;
   rv_pkg::word_t    wr_data;

   fetch_unit u_fetch (
      .clk         (clk),
      .rstn        (rstn),
      .ex_redirect (ex_redirect),
      .id_redirect (id_redirect),
      .rom_addr    (rom_addr),
      .rom_data    (rom_data),
      .fetch_out   (fetch_pkt)
   );

   decode_unit u_decode (
      .clk         (clk),
      .rstn        (rstn),
      .fetch_in    (fetch_pkt),
      .ex_redirect (ex_redirect),
      .rs1_idx     (rs1_idx),
      .rs2_idx     (rs2_idx),
      .rs1_val     (rs1_val),
      .rs2_val     (rs2_val),
      .id_redirect (id_redirect),
      .decode_out  (decode_pkt)
   );

   reg_file u_regs (
      .clk     (clk),
      .rstn    (rstn),
      .rs1_idx (rs1_idx),
      .rs2_idx (rs2_idx),
      .rs1_val (rs1_val),
      .rs2_val (rs2_val),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .wr_data (wr_data)
   );

   execute_unit u_execute (
      .clk         (clk),
      .rstn        (rstn),
      .decode_in   (decode_pkt),
      .fwd_in      (fwd_pkt),
      .ex_redirect (ex_redirect),
      .result_out  (result_pkt)
   );

   result_stage u_result (
      .clk       (clk),
      .rstn      (rstn),
      .result_in (result_pkt),
      .wr_en     (wr_en),
      .wr_idx    (wr_idx),
      .wr_data   (wr_data),
      .fwd_out   (fwd_pkt),
      .retire    (retire)
   );

endmodule

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "rv_macros.svh"

module tb_rv_core;

   localparam int            PROG_LEN        = 200;
   localparam rv_pkg::addr_t PROG_END        = 32'(4 * PROG_LEN);
   localparam int            WATCHDOG_CYCLES = 4 * PROG_LEN + 50;

   logic            clk      = 1'b0;
   logic            rstn     = 1'b1;
   rv_pkg::instr_t  rom_data = `RV_NOP_INSTR;
   rv_pkg::addr_t   rom_addr;
   rv_pkg::retire_t retire;

   rv_pkg::instr_t  prog [PROG_LEN];
   rv_pkg::retire_t exp_q[$];
   string           exp_name[$];
   int              err_count = 0;
   int              ret_count = 0;
   logic            done      = 1'b0;

   rv_core u_dut (
      .clk      (clk),
      .rstn     (rstn),
      .rom_addr (rom_addr),
      .rom_data (rom_data),
      .retire   (retire)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   ////////////////////
   // program image
   function automatic rv_pkg::instr_t rom_word(input rv_pkg::addr_t addr);
      if (addr[1:0] != 2'b00 || addr >= PROG_END) begin
         return `RV_NOP_INSTR;
      end
      return prog[int'(addr >> 2)];
   endfunction

   // small register set gives many close dependencies
   function automatic rv_pkg::reg_idx_t pick_reg();
      return rv_pkg::reg_idx_t'($urandom % 8);
   endfunction

   task automatic build_program();
      int unsigned sel;
      int unsigned span;
      int unsigned k;
      rv_pkg::reg_idx_t rd;
      rv_pkg::reg_idx_t rs1;
      rv_pkg::reg_idx_t rs2;
      logic [2:0]  f3;
      logic        alt;
      logic [11:0] imm12;
      logic [1:0]  bsel;
      logic [20:0] joff;
      logic [12:0] boff;
      for (int i = 0; i < PROG_LEN; i++) begin
         sel   = $urandom % 100;
         rd    = pick_reg();
         rs1   = pick_reg();
         rs2   = pick_reg();
         f3    = 3'($urandom % 8);
         alt   = 1'($urandom % 2);
         imm12 = 12'($urandom);
         span  = PROG_LEN - i;
         if (span > 6) begin
            span = 6;
         end
         // forward only and never past the program end
         k    = 1 + ($urandom % span);
         joff = 21'(4 * k);
         boff = 13'(4 * k);
         if (sel < 30) begin
            if (f3 != 3'd0 && f3 != 3'd5) begin
               alt = 1'b0;
            end
            prog[i] = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV_OP_OP};
         end else if (sel < 60) begin
            if (f3 == 3'd1) begin
               imm12 = {7'b0, imm12[4:0]};
            end else if (f3 == 3'd5) begin
               imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
            end
            prog[i] = {imm12, rs1, f3, rd, `RV_OP_IMM};
         end else if (sel < 65) begin
            prog[i] = {20'($urandom), rd, `RV_OP_LUI};
         end else if (sel < 70) begin
            prog[i] = {20'($urandom), rd, `RV_OP_AUIPC};
         end else if (sel < 77) begin
            prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, `RV_OP_JAL};
         end else if (sel < 83) begin
            // x0 base makes the immediate the absolute target
            prog[i] = {12'(4 * (i + k)), 5'd0, 3'b000, rd, `RV_OP_JALR};
         end else begin
            bsel    = 2'($urandom % 4);
            f3      = {bsel[1], 1'b0, bsel[0]};
            prog[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
                       `RV_OP_BRANCH};
         end
      end
   endtask

   ////////////////////
   // reference model
   function automatic rv_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                               input rv_pkg::word_t a, input rv_pkg::word_t b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5: begin
            if (alt) begin
               return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
         end
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
                                         input rv_pkg::word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         default: return 1'b0;
      endcase
   endfunction

   task automatic build_expected();
      rv_pkg::word_t    mregs [32];
      rv_pkg::addr_t    pc;
      rv_pkg::addr_t    next_pc;
      rv_pkg::instr_t   ins;
      rv_pkg::word_t    a;
      rv_pkg::word_t    b;
      rv_pkg::word_t    res;
      rv_pkg::word_t    immi;
      rv_pkg::word_t    immu;
      rv_pkg::word_t    immb;
      rv_pkg::word_t    immj;
      rv_pkg::reg_idx_t rd;
      logic [2:0]       f3;
      logic             wr;
      rv_pkg::retire_t  ent;
      string            name;
      for (int i = 0; i < 32; i++) begin
         mregs[i] = '0;
      end
      pc = `RV_RESET_PC;
      while (pc < PROG_END) begin
         ins     = rom_word(pc);
         rd      = ins[11:7];
         f3      = ins[14:12];
         a       = mregs[ins[19:15]];
         b       = mregs[ins[24:20]];
         immi    = {{20{ins[31]}}, ins[31:20]};
         immu    = {ins[31:12], 12'h000};
         immb    = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
         immj    = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
         next_pc = pc + 32'd4;
         wr      = 1'b1;
         res     = '0;
         case (ins[6:0])
            `RV_OP_OP: begin
               res  = alu_model(f3, ins[30], a, b);
               name = "alu_reg";
            end
            `RV_OP_IMM: begin
               res  = alu_model(f3, f3 == 3'd5 && ins[30], a, immi);
               name = "alu_imm";
            end
            `RV_OP_LUI: begin
               res  = immu;
               name = "lui";
            end
            `RV_OP_AUIPC: begin
               res  = pc + immu;
               name = "auipc";
            end
            `RV_OP_JAL: begin
               res     = pc + 32'd4;
               next_pc = pc + immj;
               name    = "jal";
            end
            `RV_OP_JALR: begin
               res     = pc + 32'd4;
               next_pc = (a + immi) & ~32'd1;
               name    = "jalr";
            end
            default: begin
               wr   = 1'b0;
               name = "branch";
               if (branch_taken(f3, a, b)) begin
                  next_pc = pc + immb;
               end
            end
         endcase
         if (wr && rd != '0) begin
            mregs[rd] = res;
         end else begin
            rd  = '0;
            res = '0;
            if (wr) begin
               name = "x0_write";
            end
         end
         ent.valid = 1'b1;
         ent.pc    = pc;
         ent.rd    = rd;
         ent.data  = res;
         exp_q.push_back(ent);
         exp_name.push_back(name);
         pc = next_pc;
      end
   endtask

   ////////////////////
   // checker and rom
   always @(negedge clk) begin
      if (rstn) begin
         assert (!retire.valid) else begin
            err_count = err_count + 1;
            $display("retire.valid went high while reset was asserted");
         end
         assert (rom_addr == `RV_RESET_PC) else begin
            err_count = err_count + 1;
            $display("ERR reset_pc: expected rom_addr=%h, got rom_addr=%h",
                     `RV_RESET_PC, rom_addr);
         end
      end else if (retire.valid && !done) begin
         assert (retire == exp_q[ret_count]) else begin
            err_count = err_count + 1;
            $display("ERR %s: retire %0d expected pc=%h rd=%0d data=%h, got pc=%h rd=%0d data=%h",
                     exp_name[ret_count], ret_count, exp_q[ret_count].pc,
                     exp_q[ret_count].rd, exp_q[ret_count].data,
                     retire.pc, retire.rd, retire.data);
         end
         ret_count = ret_count + 1;
         if (ret_count == exp_q.size()) begin
            done = 1'b1;
         end
      end
      rom_data <= rom_word(rom_addr);
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      if (!done) begin
         $display("timeout: only %0d of %0d instructions retired after %0d cycles",
                  ret_count, exp_q.size(), WATCHDOG_CYCLES);
         $display("Checks failed");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'habf7));
      build_program();
      build_expected();
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstn <= 1'b0;
      while (!done) begin
         @(negedge clk);
      end
      repeat (2) @(negedge clk);
      $display("errors: %0d, retired: %0d of %0d", err_count, ret_count, exp_q.size());
      if (err_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/rv_pkg.sv
src/fetch_unit.sv
src/decode_unit.sv
src/reg_file.sv
src/execute_unit.sv
src/result_stage.sv
src/rv_core.sv
tb/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_rv_core &&
./obj_dir/Vtb_rv_core | tee /dev/stderr | grep -q "All checks passed" &&
echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
